// File: bench/core_tb.sv
`timescale 1ns/1ps

module core_tb
	import core_pkg::*;
;

	logic                 clk;
	logic                 arst_n;
	logic                 run;
	logic [31:0]          instruction;
	logic                 im_read;
	logic [IM_ADDR_W-1:0] im_addr;
	logic                 dm_enable;
	logic                 dm_write;
	logic [DM_ADDR_W-1:0] dm_addr;
	logic [31:0]          dm_wdata;
	logic [31:0]          dm_rdata;
	logic                 dm_ack;
	logic                 alu_overflow;

	logic [31:0] imem [1024];
	logic [31:0] dmem [1024];
	logic [31:0] ref_mem [1024];
	logic [11:0] log_addr [$];
	logic [31:0] log_data [$];
	logic [11:0] exp_addr [$];
	logic [31:0] exp_data [$];

	int prog_len;
	int halt_pc;
	int rd_count;
	int ovf_count;
	int exp_ovf;
	int errors;
	int tests;
	int failed_tests;

	core_top dut0 (.*);

	assign instruction = imem[im_addr];

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// data memory model acking after 1 to 4 cycles
	initial begin
		int delay;
		void'($urandom(54));
		dm_ack = 1'b0;
		dm_rdata = '0;
		forever begin
			@(posedge clk);
			if (arst_n && dm_enable && !dm_ack) begin
				delay = $urandom_range(4, 1);
				repeat (delay - 1) @(posedge clk);
				if (dm_write) begin
					dmem[dm_addr[11:2]] = dm_wdata;
					log_addr.push_back(dm_addr);
					log_data.push_back(dm_wdata);
				end else begin
					dm_rdata <= dmem[dm_addr[11:2]];
					rd_count++;
				end
				dm_ack <= 1'b1;
				@(posedge clk);
				dm_ack <= 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		if (alu_overflow) begin
			ovf_count++;
		end
	end

	function automatic logic [31:0] fill_word(input int i);
		return (i * 32'h9E3779B1) ^ 32'h5A5A0000;
	endfunction

	function automatic logic [31:0] alu_rr(input logic [4:0] sub, input logic [4:0] rt,
			input logic [4:0] ra, input logic [4:0] rb);
		return {1'b0, OP_ALU, rt, ra, rb, 5'd0, sub};
	endfunction

	function automatic logic [31:0] imm_op(input logic [5:0] op, input logic [4:0] rt,
			input logic [4:0] ra, input logic [14:0] imm);
		return {1'b0, op, rt, ra, imm};
	endfunction

	function automatic logic [31:0] movi(input logic [4:0] rt, input logic [19:0] imm);
		return {1'b0, OP_MOVI, rt, imm};
	endfunction

	function automatic logic [31:0] branch(input logic ne, input logic [4:0] rt,
			input logic [4:0] ra, input logic [13:0] off);
		return {1'b0, OP_BR, rt, ra, ne, off};
	endfunction

	function automatic logic [31:0] jump(input logic [23:0] off);
		return {1'b0, OP_J, 1'b0, off};
	endfunction

	task automatic clear_prog();
		for (int i = 0; i < 1024; i++) begin
			imem[i] = '0;
		end
		prog_len = 0;
	endtask

	task automatic emit(input logic [31:0] w);
		imem[prog_len] = w;
		prog_len++;
	endtask

	task automatic emit_halt();
		halt_pc = prog_len;
		emit(jump(24'd0));
	endtask

	// instruction-level model of the program
	task automatic model_run();
		logic [31:0] r [32];
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] t;
		logic [31:0] res;
		logic [11:0] addr;
		longint wide;
		int pc;
		int steps;
		bit done;
		for (int i = 0; i < 32; i++) begin
			r[i] = '0;
		end
		pc = 0;
		steps = 0;
		done = 0;
		exp_ovf = 0;
		while (!done && steps < 4000) begin
			ins = imem[pc];
			a = r[ins[19:15]];
			b = r[ins[14:10]];
			t = r[ins[24:20]];
			pc = (pc + 1) & 1023;
			steps++;
			case (ins[30:25])
				OP_ALU: begin
					case (ins[4:0])
						SUB_ADD: begin
							res = a + b;
							wide = longint'($signed(a)) + longint'($signed(b));
							if (wide != longint'($signed(res))) exp_ovf++;
						end
						SUB_SUB: begin
							res = a - b;
							wide = longint'($signed(a)) - longint'($signed(b));
							if (wide != longint'($signed(res))) exp_ovf++;
						end
						SUB_AND: res = a & b;
						SUB_OR:  res = a | b;
						default: res = a ^ b;
					endcase
					r[ins[24:20]] = res;
				end
				OP_ADDI: begin
					b = {{17{ins[14]}}, ins[14:0]};
					res = a + b;
					wide = longint'($signed(a)) + longint'($signed(b));
					if (wide != longint'($signed(res))) exp_ovf++;
					r[ins[24:20]] = res;
				end
				OP_ORI:  r[ins[24:20]] = a | {17'd0, ins[14:0]};
				OP_MOVI: r[ins[24:20]] = {{12{ins[19]}}, ins[19:0]};
				OP_LWI: begin
					addr = a[11:0] + {ins[9:0], 2'b00};
					r[ins[24:20]] = ref_mem[addr[11:2]];
				end
				OP_SWI: begin
					addr = a[11:0] + {ins[9:0], 2'b00};
					ref_mem[addr[11:2]] = t;
					exp_addr.push_back(addr);
					exp_data.push_back(t);
				end
				OP_BR: begin
					if (ins[14] ? (t != a) : (t == a)) begin
						pc = (pc - 1 + int'($signed(ins[13:0]))) & 1023;
					end
				end
				OP_J: begin
					if (ins[23:0] == '0) begin
						done = 1;
					end else begin
						pc = (pc - 1 + int'($signed(ins[23:0]))) & 1023;
					end
				end
				default: ;
			endcase
			r[0] = '0;
		end
	endtask

	task automatic reset_core();
		arst_n <= 1'b0;
		run <= 1'b0;
		for (int i = 0; i < 1024; i++) begin
			dmem[i] = fill_word(i);
			ref_mem[i] = fill_word(i);
		end
		log_addr.delete();
		log_data.delete();
		exp_addr.delete();
		exp_data.delete();
		repeat (3) @(posedge clk);
		rd_count = 0;
		ovf_count = 0;
		arst_n <= 1'b1;
		@(posedge clk);
		if (im_read !== 1'b0) begin
			errors++;
			$display("Error: im_read after reset expected 0 got %h", im_read);
		end
	endtask

	// runs until the halt loop idles, optionally dropping run for a while
	task automatic run_prog(input string name, input int hold_at, input int hold_len);
		int cyc;
		int idle;
		bit prev_en;
		bit in_hold;
		cyc = 0;
		idle = 0;
		prev_en = 0;
		run <= 1'b1;
		while (idle < 10) begin
			@(posedge clk);
			cyc++;
			in_hold = hold_len > 0 && cyc > hold_at + 1 && cyc <= hold_at + hold_len;
			if (in_hold && dm_enable && !prev_en) begin
				errors++;
				$display("%s: bus access started while run was low", name);
			end
			if (in_hold && im_read) begin
				errors++;
				$display("%s: instruction fetch active while run was low", name);
			end
			prev_en = dm_enable;
			if (im_read && !dm_enable && (im_addr == halt_pc || im_addr == halt_pc + 1)) begin
				idle++;
			end else begin
				idle = 0;
			end
			if (hold_len > 0 && cyc == hold_at) run <= 1'b0;
			if (hold_len > 0 && cyc == hold_at + hold_len) run <= 1'b1;
			if (cyc > 3000) begin
				$display("%s: timeout, the halt loop was never reached", name);
				$display("Result: FAILED");
				$finish;
			end
		end
		run <= 1'b0;
	endtask

	task automatic compare_log(input string name);
		if (log_addr.size() != exp_addr.size()) begin
			errors++;
			$display("%s: wrong number of bus writes, expected %0d, seen %0d", name,
				exp_addr.size(), log_addr.size());
		end else begin
			for (int i = 0; i < exp_addr.size(); i++) begin
				if (log_addr[i] != exp_addr[i]) begin
					errors++;
					$display("Error: dm_addr write %0d expected %h got %h", i, exp_addr[i],
						log_addr[i]);
				end
				if (log_data[i] != exp_data[i]) begin
					errors++;
					$display("Error: dm_wdata write %0d expected %h got %h", i, exp_data[i],
						log_data[i]);
				end
			end
		end
		if (ovf_count != exp_ovf) begin
			errors++;
			$display("Error: alu_overflow pulses expected %h got %h", exp_ovf, ovf_count);
		end
	endtask

	task automatic execute(input string name, input int hold_at, input int hold_len);
		reset_core();
		model_run();
		run_prog(name, hold_at, hold_len);
		compare_log(name);
	endtask

	task automatic report(input string name, input int errs_before);
		tests++;
		if (errors != errs_before) failed_tests++;
		$display("%s: %s (%0d errors)", name, (errors == errs_before) ? "ok" : "failing",
			errors - errs_before);
	endtask

	task automatic alu_forwarding();
		int e;
		e = errors;
		clear_prog();
		emit(movi(5'd1, 20'h12345));
		emit(alu_rr(SUB_ADD, 5'd2, 5'd1, 5'd1));
		emit(alu_rr(SUB_SUB, 5'd3, 5'd2, 5'd1));
		emit(alu_rr(SUB_AND, 5'd4, 5'd3, 5'd2));
		emit(alu_rr(SUB_OR, 5'd5, 5'd4, 5'd1));
		emit(alu_rr(SUB_XOR, 5'd6, 5'd5, 5'd3));
		emit(imm_op(OP_ADDI, 5'd7, 5'd6, 15'h7FFD));
		emit(imm_op(OP_ORI, 5'd8, 5'd7, 15'h4F0F));
		for (int k = 1; k <= 8; k++) begin
			emit(imm_op(OP_SWI, 5'(k), 5'd0, 15'(k)));
		end
		emit_halt();
		execute("alu_chain", 0, 0);
		report("alu_chain", e);
	endtask

	task automatic build_load_prog();
		clear_prog();
		emit(movi(5'd1, 20'h00777));
		emit(imm_op(OP_SWI, 5'd1, 5'd0, 15'd16));
		emit(imm_op(OP_LWI, 5'd2, 5'd0, 15'd16));
		emit(alu_rr(SUB_ADD, 5'd3, 5'd2, 5'd1));
		emit(imm_op(OP_SWI, 5'd3, 5'd0, 15'd17));
		emit(imm_op(OP_LWI, 5'd4, 5'd0, 15'd16));
		emit(imm_op(OP_LWI, 5'd5, 5'd0, 15'd40));
		emit(alu_rr(SUB_ADD, 5'd6, 5'd4, 5'd5));
		emit(imm_op(OP_SWI, 5'd6, 5'd0, 15'd18));
		emit_halt();
	endtask

	task automatic load_use_hit();
		int e;
		e = errors;
		build_load_prog();
		execute("load_use", 0, 0);
		// first load of A misses, second hits, unwritten word misses
		if (rd_count != 2) begin
			errors++;
			$display("Error: dm bus reads expected %h got %h", 2, rd_count);
		end
		report("load_use", e);
	endtask

	task automatic write_through();
		int e;
		e = errors;
		clear_prog();
		emit(movi(5'd1, 20'h000A1));
		emit(imm_op(OP_SWI, 5'd1, 5'd0, 15'd4));
		emit(movi(5'd2, 20'h000B2));
		emit(imm_op(OP_SWI, 5'd2, 5'd0, 15'd20));
		emit(imm_op(OP_LWI, 5'd3, 5'd0, 15'd20));
		emit(imm_op(OP_SWI, 5'd1, 5'd0, 15'd20));
		emit(imm_op(OP_SWI, 5'd3, 5'd0, 15'd36));
		emit(imm_op(OP_LWI, 5'd4, 5'd0, 15'd20));
		emit(imm_op(OP_SWI, 5'd4, 5'd0, 15'd60));
		emit_halt();
		execute("write_through", 0, 0);
		report("write_through", e);
	endtask

	task automatic branch_flush();
		int e;
		e = errors;
		clear_prog();
		emit(movi(5'd1, 20'd7));
		emit(movi(5'd2, 20'd7));
		emit(movi(5'd3, 20'd9));
		emit(branch(1'b0, 5'd1, 5'd2, 14'd2));
		emit(imm_op(OP_SWI, 5'd3, 5'd0, 15'd50));
		emit(branch(1'b0, 5'd1, 5'd3, 14'd2));
		emit(imm_op(OP_SWI, 5'd1, 5'd0, 15'd51));
		emit(branch(1'b1, 5'd1, 5'd2, 14'd2));
		emit(imm_op(OP_SWI, 5'd2, 5'd0, 15'd52));
		emit(branch(1'b1, 5'd1, 5'd3, 14'd2));
		emit(imm_op(OP_SWI, 5'd3, 5'd0, 15'd53));
		emit(jump(24'd2));
		emit(imm_op(OP_SWI, 5'd3, 5'd0, 15'd54));
		emit(imm_op(OP_SWI, 5'd3, 5'd0, 15'd55));
		emit_halt();
		execute("branches", 0, 0);
		report("branches", e);
	endtask

	task automatic signed_overflow();
		int e;
		e = errors;
		clear_prog();
		// 2^18 doubled twelve times gives 2^30
		emit(movi(5'd1, 20'h40000));
		for (int k = 0; k < 12; k++) begin
			emit(alu_rr(SUB_ADD, 5'd1, 5'd1, 5'd1));
		end
		emit(imm_op(OP_ADDI, 5'd2, 5'd1, 15'h7FFF));
		emit(alu_rr(SUB_ADD, 5'd3, 5'd1, 5'd2));
		emit(movi(5'd4, 20'd1));
		emit(alu_rr(SUB_ADD, 5'd5, 5'd3, 5'd4));
		emit(alu_rr(SUB_ADD, 5'd6, 5'd4, 5'd4));
		emit(imm_op(OP_SWI, 5'd5, 5'd0, 15'd8));
		emit(imm_op(OP_SWI, 5'd6, 5'd0, 15'd9));
		emit_halt();
		execute("overflow", 0, 0);
		if (ovf_count != 1) begin
			errors++;
			$display("Error: alu_overflow pulses expected %h got %h", 1, ovf_count);
		end
		report("overflow", e);
	endtask

	task automatic run_hold();
		int e;
		e = errors;
		build_load_prog();
		execute("run_hold", 10, 8);
		execute("run_hold", 17, 5);
		report("run_hold", e);
	endtask

	initial begin
		arst_n = 1'b0;
		run = 1'b0;
		errors = 0;
		tests = 0;
		failed_tests = 0;
		clear_prog();
		halt_pc = 0;
		alu_forwarding();
		load_use_hit();
		write_through();
		branch_flush();
		signed_overflow();
		run_hold();
		$display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: bench/core_tb_assert.sv
`timescale 1ns/1ps

module core_tb_assert
	import core_pkg::*;
(
	input logic                 clk,
	input logic                 arst_n,
	input logic                 dm_enable,
	input logic                 dm_write,
	input logic [DM_ADDR_W-1:0] dm_addr,
	input logic [31:0]          dm_wdata,
	input logic                 dm_ack,
	input logic                 alu_overflow
);

	no_bus_in_reset: assert property (@(posedge clk) !arst_n |-> !dm_enable)
		else $error("dm_enable high during reset");

	// request fields hold until the ack
	bus_stable: assert property (@(posedge clk) disable iff (!arst_n)
		dm_enable && !dm_ack |=> $stable(dm_addr) && $stable(dm_write) && $stable(dm_wdata))
		else $error("data bus request changed before ack");

	enable_drops: assert property (@(posedge clk) disable iff (!arst_n)
		dm_ack |=> !dm_enable)
		else $error("dm_enable still high after ack");

	ovf_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
		alu_overflow |=> !alu_overflow)
		else $error("alu_overflow longer than one cycle");

endmodule

bind core_top core_tb_assert u_check (.*);

// File: list.f
src/core_pkg.sv
src/pipe_reg.sv
src/fetch_pc.sv
src/decoder.sv
src/regfile.sv
src/hazard_forward.sv
src/alu.sv
src/dcache.sv
src/core_top.sv
bench/core_tb_assert.sv
bench/core_tb.sv

// File: src/alu.sv
`timescale 1ns/1ps

module alu
	import core_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  logic        hold,
	input  id_ex_t      ex,
	output logic [31:0] result,
	output logic        overflow_pulse
);

	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] sum;
	logic [31:0] diff;
	logic        ovf;

	assign a = ex.src_a;
	assign b = ex.src_b;
	assign sum = a + b;
	assign diff = a - b;

	always_comb begin
		ovf = 1'b0;
		case (ex.ctrl.alu_op)
			ALU_ADD: begin
				result = sum;
				ovf = (a[31] == b[31]) && (sum[31] != a[31]);
			end
			ALU_SUB: begin
				result = diff;
				ovf = (a[31] != b[31]) && (diff[31] != a[31]);
			end
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_XOR: result = a ^ b;
			default: result = b;
		endcase
	end

	// address adds of lwi/swi never flag
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			overflow_pulse <= 1'b0;
		end else begin
			overflow_pulse <= ~hold & ex.valid & ex.ctrl.reg_write & ~ex.ctrl.mem_read & ovf;
		end
	end

endmodule

// File: src/core_pkg.sv
package core_pkg;

	// major opcodes, instr[30:25]
	localparam logic [5:0] OP_ALU  = 6'b100000;
	localparam logic [5:0] OP_ADDI = 6'b101000;
	localparam logic [5:0] OP_ORI  = 6'b101100;
	localparam logic [5:0] OP_MOVI = 6'b100010;
	localparam logic [5:0] OP_LWI  = 6'b000010;
	localparam logic [5:0] OP_SWI  = 6'b001010;
	localparam logic [5:0] OP_BR   = 6'b100110;
	localparam logic [5:0] OP_J    = 6'b100100;

	// alu sub-ops, instr[4:0]
	localparam logic [4:0] SUB_ADD = 5'b00000;
	localparam logic [4:0] SUB_SUB = 5'b00001;
	localparam logic [4:0] SUB_AND = 5'b00010;
	localparam logic [4:0] SUB_XOR = 5'b00011;
	localparam logic [4:0] SUB_OR  = 5'b00100;

	// field positions
	localparam int REG_AW   = 5;
	localparam int OPC_LSB  = 25;
	localparam int RT_LSB   = 20;
	localparam int RA_LSB   = 15;
	localparam int RB_LSB   = 10;
	localparam int BR_SENSE = 14;

	// memory and cache geometry
	localparam int CACHE_LINES = 16;
	localparam int DM_ADDR_W   = 12;
	localparam int IM_ADDR_W   = 10;
	localparam int INDEX_W     = $clog2(CACHE_LINES);
	localparam int TAG_W       = DM_ADDR_W - INDEX_W - 2;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS_B
	} alu_op_e;

	typedef struct packed {
		alu_op_e           alu_op;
		logic              mem_read;
		logic              mem_write;
		logic              reg_write;
		logic [REG_AW-1:0] wr_addr;
	} ctrl_t;

	typedef struct packed {
		logic                 valid;
		logic [IM_ADDR_W-1:0] pc;
		logic [31:0]          instr;
	} if_id_t;

	typedef struct packed {
		logic        valid;
		ctrl_t       ctrl;
		logic [31:0] src_a;
		logic [31:0] src_b;
		logic [31:0] store_data;
	} id_ex_t;

	typedef struct packed {
		logic        valid;
		ctrl_t       ctrl;
		logic [31:0] result;
		logic [31:0] store_data;
	} ex_mem_t;

	typedef struct packed {
		logic              valid;
		logic              reg_write;
		logic [REG_AW-1:0] wr_addr;
		logic [31:0]       wr_data;
	} mem_wb_t;

endpackage

// File: src/core_top.sv
`timescale 1ns/1ps

module core_top
	import core_pkg::*;
(
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 run,
	input  logic [31:0]          instruction,
	output logic                 im_read,
	output logic [IM_ADDR_W-1:0] im_addr,
	output logic                 dm_enable,
	output logic                 dm_write,
	output logic [DM_ADDR_W-1:0] dm_addr,
	output logic [31:0]          dm_wdata,
	input  logic [31:0]          dm_rdata,
	input  logic                 dm_ack,
	output logic                 alu_overflow
);

	if_id_t  if_id_d;
	if_id_t  if_id_q;
	id_ex_t  id_ex_d;
	id_ex_t  id_ex_q;
	ex_mem_t ex_mem_d;
	ex_mem_t ex_mem_q;
	ex_mem_t mem_fwd;
	mem_wb_t mem_wb_d;
	mem_wb_t mem_wb_q;

	logic [IM_ADDR_W-1:0] pc;
	logic [IM_ADDR_W-1:0] target;
	logic                 flush_fetch;
	logic                 dec_redirect;
	logic                 redirect;
	ctrl_t                dec_ctrl;
	logic [31:0]          dec_src_b;
	logic [REG_AW-1:0]    ra_addr;
	logic [REG_AW-1:0]    rb_addr;
	logic [REG_AW-1:0]    rt_addr;
	logic [31:0]          ra_data;
	logic [31:0]          rb_data;
	logic [31:0]          rt_data;
	logic [31:0]          fwd_a;
	logic [31:0]          fwd_b;
	logic [31:0]          fwd_t;
	logic [31:0]          ex_result;
	logic [31:0]          cache_rdata;
	logic                 load_stall;
	logic                 stall_all;
	logic                 fetch_hold;
	logic                 mem_op;
	logic                 cache_req;
	logic                 cache_ready;
	logic                 busy_q;
	logic                 served;

	assign stall_all = ~run | ~cache_ready;
	assign fetch_hold = stall_all | load_stall;
	// operands of a branch behind a load are not ready yet
	assign redirect = dec_redirect & ~load_stall;

	assign im_read = ~fetch_hold;
	assign im_addr = pc;

	assign ra_addr = if_id_q.instr[RA_LSB +: REG_AW];
	assign rb_addr = if_id_q.instr[RB_LSB +: REG_AW];
	assign rt_addr = if_id_q.instr[RT_LSB +: REG_AW];

	assign if_id_d = '{valid: 1'b1, pc: pc, instr: instruction};
	assign id_ex_d = '{valid: if_id_q.valid, ctrl: dec_ctrl, src_a: fwd_a,
		src_b: dec_src_b, store_data: fwd_t};
	assign ex_mem_d = '{valid: id_ex_q.valid, ctrl: id_ex_q.ctrl, result: ex_result,
		store_data: id_ex_q.store_data};
	assign mem_wb_d = '{valid: ex_mem_q.valid, reg_write: ex_mem_q.ctrl.reg_write,
		wr_addr: ex_mem_q.ctrl.wr_addr,
		wr_data: ex_mem_q.ctrl.mem_read ? cache_rdata : ex_mem_q.result};

	// memory stage forwards its write-back value, load data included
	always_comb begin
		mem_fwd = ex_mem_q;
		mem_fwd.result = mem_wb_d.wr_data;
	end

	// a finished access is not reissued while run is low
	assign mem_op = ex_mem_q.valid & (ex_mem_q.ctrl.mem_read | ex_mem_q.ctrl.mem_write);
	assign cache_req = mem_op & run & ~served;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy_q <= 1'b0;
			served <= 1'b0;
		end else begin
			busy_q <= ~cache_ready;
			if (!stall_all) begin
				served <= 1'b0;
			end else if (busy_q && cache_ready && !run) begin
				served <= 1'b1;
			end
		end
	end

	fetch_pc u_fetch (.clk(clk), .arst_n(arst_n), .hold(fetch_hold), .redirect(redirect),
		.target(target), .pc(pc), .flush_fetch(flush_fetch));

	decoder u_decoder (.fetched(if_id_q), .op_a(fwd_a), .op_b(fwd_b), .op_t(fwd_t),
		.ctrl(dec_ctrl), .imm(), .src_b(dec_src_b), .redirect(dec_redirect),
		.target(target));

	regfile u_regfile (.clk(clk), .arst_n(arst_n), .ra_addr(ra_addr), .rb_addr(rb_addr),
		.rt_addr(rt_addr), .wb(mem_wb_q), .ra_data(ra_data), .rb_data(rb_data),
		.rt_data(rt_data));

	hazard_forward u_hazard (.ra_addr(ra_addr), .rb_addr(rb_addr), .rt_addr(rt_addr),
		.ra_data(ra_data), .rb_data(rb_data), .rt_data(rt_data), .ex(id_ex_q),
		.ex_result(ex_result), .mem(mem_fwd), .wb(mem_wb_q), .fwd_a(fwd_a),
		.fwd_b(fwd_b), .fwd_t(fwd_t), .load_stall(load_stall));

	alu u_alu (.clk(clk), .arst_n(arst_n), .hold(stall_all), .ex(id_ex_q),
		.result(ex_result), .overflow_pulse(alu_overflow));

	dcache u_dcache (.clk(clk), .arst_n(arst_n), .req(cache_req),
		.req_write(ex_mem_q.ctrl.mem_write), .req_addr(ex_mem_q.result[DM_ADDR_W-1:0]),
		.req_wdata(ex_mem_q.store_data), .rdata(cache_rdata), .ready(cache_ready),
		.dm_enable(dm_enable), .dm_write(dm_write), .dm_addr(dm_addr),
		.dm_wdata(dm_wdata), .dm_rdata(dm_rdata), .dm_ack(dm_ack));

	// load-use keeps fetch and if/id, bubbles id/ex
	pipe_reg #(.payload_t(if_id_t)) u_if_id (.clk(clk), .arst_n(arst_n),
		.hold(fetch_hold), .flush(flush_fetch), .d(if_id_d), .q(if_id_q));
	pipe_reg #(.payload_t(id_ex_t)) u_id_ex (.clk(clk), .arst_n(arst_n),
		.hold(stall_all), .flush(load_stall), .d(id_ex_d), .q(id_ex_q));
	pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (.clk(clk), .arst_n(arst_n),
		.hold(stall_all), .flush(1'b0), .d(ex_mem_d), .q(ex_mem_q));
	pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (.clk(clk), .arst_n(arst_n),
		.hold(stall_all), .flush(1'b0), .d(mem_wb_d), .q(mem_wb_q));

endmodule

// File: src/dcache.sv
`timescale 1ns/1ps

module dcache
	import core_pkg::*;
(
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 req,
	input  logic                 req_write,
	input  logic [DM_ADDR_W-1:0] req_addr,
	input  logic [31:0]          req_wdata,
	output logic [31:0]          rdata,
	output logic                 ready,
	output logic                 dm_enable,
	output logic                 dm_write,
	output logic [DM_ADDR_W-1:0] dm_addr,
	output logic [31:0]          dm_wdata,
	input  logic [31:0]          dm_rdata,
	input  logic                 dm_ack
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_READ,
		S_WRITE,
		S_DONE
	} state_e;

	state_e state;
	state_e state_nx;

	logic [CACHE_LINES-1:0] line_valid;
	logic [TAG_W-1:0]       line_tag [CACHE_LINES];
	logic [31:0]            line_data [CACHE_LINES];

	logic [INDEX_W-1:0] index;
	logic [TAG_W-1:0]   tag;
	logic [INDEX_W-1:0] fill_index;
	logic [TAG_W-1:0]   fill_tag;
	logic               hit;
	logic               line_hit;
	logic               start;
	logic               fill;

	// lookup on the pipeline address
	assign index = req_addr[2 +: INDEX_W];
	assign tag = req_addr[DM_ADDR_W-1 -: TAG_W];
	assign hit = line_valid[index] && (line_tag[index] == tag);
	assign rdata = line_data[index];

	// every store and every read miss goes to the bus
	assign start = (state == S_IDLE) && req && (req_write || !hit);
	assign ready = !start && (state == S_IDLE || state == S_DONE);

	assign dm_enable = (state == S_READ) || (state == S_WRITE);
	assign dm_write = (state == S_WRITE);

	// line update uses the latched bus address
	assign fill_index = dm_addr[2 +: INDEX_W];
	assign fill_tag = dm_addr[DM_ADDR_W-1 -: TAG_W];
	assign line_hit = line_valid[fill_index] && (line_tag[fill_index] == fill_tag);
	assign fill = dm_ack && ((state == S_READ) || (state == S_WRITE && line_hit));

	always_comb begin
		state_nx = state;
		case (state)
			S_IDLE: begin
				if (start) begin
					state_nx = req_write ? S_WRITE : S_READ;
				end
			end
			S_READ, S_WRITE: begin
				if (dm_ack) begin
					state_nx = S_DONE;
				end
			end
			default: state_nx = S_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= S_IDLE;
			line_valid <= '0;
		end else begin
			state <= state_nx;
			if (fill) begin
				line_valid[fill_index] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			dm_addr <= req_addr;
			dm_wdata <= req_wdata;
		end
		if (fill) begin
			line_tag[fill_index] <= fill_tag;
			line_data[fill_index] <= (state == S_READ) ? dm_rdata : dm_wdata;
		end
	end

endmodule

// File: src/decoder.sv
`timescale 1ns/1ps

module decoder
	import core_pkg::*;
(
	input  if_id_t               fetched,
	input  logic [31:0]          op_a,
	input  logic [31:0]          op_b,
	input  logic [31:0]          op_t,
	output ctrl_t                ctrl,
	output logic [31:0]          imm,
	output logic [31:0]          src_b,
	output logic                 redirect,
	output logic [IM_ADDR_W-1:0] target
);

	logic [5:0]  opcode;
	logic [4:0]  sub_op;
	logic [31:0] offset;
	logic        taken;

	assign opcode = fetched.instr[OPC_LSB +: 6];
	assign sub_op = fetched.instr[4:0];

	always_comb begin
		case (opcode)
			OP_ORI:  imm = {17'd0, fetched.instr[14:0]};
			OP_MOVI: imm = {{12{fetched.instr[19]}}, fetched.instr[19:0]};
			// word offset for loads and stores
			OP_LWI, OP_SWI: imm = {{15{fetched.instr[14]}}, fetched.instr[14:0], 2'b00};
			default: imm = {{17{fetched.instr[14]}}, fetched.instr[14:0]};
		endcase
	end

	assign src_b = (opcode == OP_ALU) ? op_b : imm;

	always_comb begin
		ctrl = '0;
		ctrl.alu_op = ALU_ADD;
		ctrl.wr_addr = fetched.instr[RT_LSB +: REG_AW];
		case (opcode)
			OP_ALU: begin
				ctrl.reg_write = 1'b1;
				case (sub_op)
					SUB_ADD: ctrl.alu_op = ALU_ADD;
					SUB_SUB: ctrl.alu_op = ALU_SUB;
					SUB_AND: ctrl.alu_op = ALU_AND;
					SUB_OR:  ctrl.alu_op = ALU_OR;
					SUB_XOR: ctrl.alu_op = ALU_XOR;
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			OP_ADDI: ctrl.reg_write = 1'b1;
			OP_ORI: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_op = ALU_OR;
			end
			OP_MOVI: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_op = ALU_PASS_B;
			end
			OP_LWI: begin
				ctrl.reg_write = 1'b1;
				ctrl.mem_read = 1'b1;
			end
			OP_SWI: ctrl.mem_write = 1'b1;
			default: ;
		endcase
		if (!fetched.valid) begin
			ctrl.reg_write = 1'b0;
			ctrl.mem_read = 1'b0;
			ctrl.mem_write = 1'b0;
		end
	end

	// beq/bne compare rt with ra
	always_comb begin
		taken = 1'b0;
		offset = {{18{fetched.instr[13]}}, fetched.instr[13:0]};
		if (opcode == OP_BR) begin
			taken = fetched.instr[BR_SENSE] ? (op_t != op_a) : (op_t == op_a);
		end else if (opcode == OP_J) begin
			taken = 1'b1;
			offset = {{8{fetched.instr[23]}}, fetched.instr[23:0]};
		end
	end

	assign redirect = fetched.valid & taken;
	assign target = fetched.pc + offset[IM_ADDR_W-1:0];

endmodule

// File: src/fetch_pc.sv
`timescale 1ns/1ps

module fetch_pc
	import core_pkg::*;
(
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 hold,
	input  logic                 redirect,
	input  logic [IM_ADDR_W-1:0] target,
	output logic [IM_ADDR_W-1:0] pc,
	output logic                 flush_fetch
);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
		end else if (!hold) begin
			if (redirect) begin
				pc <= target;
			end else begin
				pc <= pc + 1'b1;
			end
		end
	end

	// drop the word fetched behind a taken branch
	assign flush_fetch = redirect & ~hold;

endmodule

// File: src/hazard_forward.sv
`timescale 1ns/1ps

module hazard_forward
	import core_pkg::*;
(
	input  logic [REG_AW-1:0] ra_addr,
	input  logic [REG_AW-1:0] rb_addr,
	input  logic [REG_AW-1:0] rt_addr,
	input  logic [31:0]       ra_data,
	input  logic [31:0]       rb_data,
	input  logic [31:0]       rt_data,
	input  id_ex_t            ex,
	input  logic [31:0]       ex_result,
	input  ex_mem_t           mem,
	input  mem_wb_t           wb,
	output logic [31:0]       fwd_a,
	output logic [31:0]       fwd_b,
	output logic [31:0]       fwd_t,
	output logic              load_stall
);

	logic ex_load;

	// youngest writer first
	function automatic logic [31:0] pick(input logic [REG_AW-1:0] addr,
			input logic [31:0] rdata);
		logic [31:0] val;
		val = rdata;
		if (addr != '0) begin
			if (ex.valid && ex.ctrl.reg_write && !ex.ctrl.mem_read &&
					ex.ctrl.wr_addr == addr) begin
				val = ex_result;
			end else if (mem.valid && mem.ctrl.reg_write && mem.ctrl.wr_addr == addr) begin
				val = mem.result;
			end else if (wb.valid && wb.reg_write && wb.wr_addr == addr) begin
				val = wb.wr_data;
			end
		end
		return val;
	endfunction

	always_comb begin
		fwd_a = pick(ra_addr, ra_data);
		fwd_b = pick(rb_addr, rb_data);
		fwd_t = pick(rt_addr, rt_data);
	end

	// load data is not there until memory stage
	assign ex_load = ex.valid & ex.ctrl.mem_read & ex.ctrl.reg_write &
		(ex.ctrl.wr_addr != '0);
	assign load_stall = ex_load & ((ex.ctrl.wr_addr == ra_addr) |
		(ex.ctrl.wr_addr == rb_addr) | (ex.ctrl.wr_addr == rt_addr));

endmodule

// File: src/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     hold,
	input  logic     flush,
	input  payload_t d,
	output payload_t q
);

	// hold wins over flush
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			q <= '0;
		end else if (!hold) begin
			if (flush) begin
				q <= '0;
			end else begin
				q <= d;
			end
		end
	end

endmodule

// File: src/regfile.sv
`timescale 1ns/1ps

module regfile
	import core_pkg::*;
(
	input  logic              clk,
	input  logic              arst_n,
	input  logic [REG_AW-1:0] ra_addr,
	input  logic [REG_AW-1:0] rb_addr,
	input  logic [REG_AW-1:0] rt_addr,
	input  mem_wb_t           wb,
	output logic [31:0]       ra_data,
	output logic [31:0]       rb_data,
	output logic [31:0]       rt_data
);

	logic [31:0] regs [32];
	logic        wr_en;

	assign wr_en = wb.valid & wb.reg_write & (wb.wr_addr != '0);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wb.wr_addr] <= wb.wr_data;
		end
	end

	// same-cycle write shows through
	assign ra_data = (ra_addr == '0) ? '0 :
		(wr_en && wb.wr_addr == ra_addr) ? wb.wr_data : regs[ra_addr];
	assign rb_data = (rb_addr == '0) ? '0 :
		(wr_en && wb.wr_addr == rb_addr) ? wb.wr_data : regs[rb_addr];
	assign rt_data = (rt_addr == '0) ? '0 :
		(wr_en && wb.wr_addr == rt_addr) ? wb.wr_data : regs[rt_addr];

endmodule
